/* gpr_config.svh */
// Build-time constants for the general register file.
// Included by the package and by every RTL file that needs a size code,
// the register count or the reset value.

`ifndef GPR_CONFIG_SVH
`define GPR_CONFIG_SVH

// operand size codes, code 3 is reserved and reads or writes nothing
`define GPR_SIZE_32 2'd0
`define GPR_SIZE_16 2'd1
`define GPR_SIZE_8  2'd2

// eax, ecx, edx, ebx, esp, ebp, esi, edi
`define GPR_COUNT 8

// value every register takes while rst_n is low
`define GPR_RESET_VALUE 32'h0000_0000

`endif

/* gpr_pkg.sv */
// Shared types of the general register file.
// Imported by the RTL modules and by the testbench side so that
// request, load and bank layouts stay in one place.

`include "gpr_config.svh"

package gpr_pkg;

    // plain vectors with a meaning
    typedef logic [31:0] word_t;
    typedef logic [2:0]  reg_idx_t;
    typedef logic [1:0]  opsize_t;

    // ------------------------------------------------------------------------
    // request and load bundles
    // ------------------------------------------------------------------------

    // writeback from the end of the pipe, idx is the architectural name
    typedef struct packed {
        logic     en;
        reg_idx_t idx;
        opsize_t  size;
        word_t    data;
    } wb_req_t;

    // direct full-width loads of esi and edi by string instructions
    typedef struct packed {
        logic  esi_en;
        word_t esi_data;
        logic  edi_en;
        word_t edi_data;
    } str_upd_t;

    // writeback after name mapping and merge, idx is the physical register
    typedef struct packed {
        logic     en;
        reg_idx_t idx;
        word_t    data;
    } wb_load_t;

    // the whole register state, eax in the lowest word
    typedef word_t [`GPR_COUNT-1:0] gpr_bank_t;

endpackage

/* gpr_read_port.sv */
// Size-aware operand read of the register file.
// Picks a register by index and returns the 32-bit, 16-bit or 8-bit
// field, zero-extended. Purely combinational, one instance per operand.

`timescale 1ns/10ps

`include "gpr_config.svh"

module gpr_read_port
    import gpr_pkg::*;
(
    input  gpr_bank_t regs,
    input  reg_idx_t  idx,
    input  opsize_t   size,
    output word_t     value
);

    // register named directly by idx, used for the 32 and 16 bit views
    word_t      sel_word;
    // register behind an 8-bit name
    word_t      byte_word;
    reg_idx_t   byte_reg;
    logic       high_byte;
    logic [7:0] byte_val;

    // ------------------------------------------------------------------------
    // 8-bit name mapping
    // ------------------------------------------------------------------------

    // al, cl, dl, bl are indices 0-3 and ah, ch, dh, bh are 4-7
    // on the same four registers
    assign high_byte = idx[2];
    assign byte_reg  = {1'b0, idx[1:0]};

    assign sel_word  = regs[idx];
    assign byte_word = regs[byte_reg];
    assign byte_val  = high_byte ? byte_word[15:8] : byte_word[7:0];

    // ------------------------------------------------------------------------
    // size select
    // ------------------------------------------------------------------------

    always_comb begin
        case (size)
            `GPR_SIZE_32: value = sel_word;
            `GPR_SIZE_16: value = {16'h0000, sel_word[15:0]};
            `GPR_SIZE_8:  value = {24'h00_0000, byte_val};
            // reserved code reads as zero
            default:      value = '0;
        endcase
    end

endmodule

/* gpr_write_merge.sv */
// Writeback merge for the general register file.
// Maps the architectural name of a writeback onto its physical register
// and splices the new bits into that register's current value, so the
// array only ever sees full 32-bit loads.

`timescale 1ns/10ps

`include "gpr_config.svh"

module gpr_write_merge
    import gpr_pkg::*;
(
    input  gpr_bank_t regs,
    input  wb_req_t   wb,
    output wb_load_t  load
);

    reg_idx_t target;
    logic     high_byte;
    logic     size_ok;
    word_t    old_word;
    word_t    merged;

    // ------------------------------------------------------------------------
    // target register
    // ------------------------------------------------------------------------

    // only an 8-bit write to ah, ch, dh or bh lands one byte up
    // in eax..ebx, every other size uses the index as given
    assign high_byte = (wb.size == `GPR_SIZE_8) && wb.idx[2];

    always_comb begin
        if (high_byte) begin
            target = {1'b0, wb.idx[1:0]};
        end else begin
            target = wb.idx;
        end
    end

    assign old_word = regs[target];

    // ------------------------------------------------------------------------
    // merge
    // ------------------------------------------------------------------------

    always_comb begin
        size_ok = 1'b1;
        case (wb.size)
            `GPR_SIZE_32: begin
                merged = wb.data;
            end
            `GPR_SIZE_16: begin
                merged = {old_word[31:16], wb.data[15:0]};
            end
            `GPR_SIZE_8: begin
                if (high_byte) begin
                    merged = {old_word[31:16], wb.data[7:0], old_word[7:0]};
                end else begin
                    merged = {old_word[31:8], wb.data[7:0]};
                end
            end
            default: begin
                // reserved size, the load is dropped below
                merged  = old_word;
                size_ok = 1'b0;
            end
        endcase
    end

    assign load.en   = wb.en && size_ok;
    assign load.idx  = target;
    assign load.data = merged;

endmodule

/* gpr_array.sv */
// Storage of the eight general registers.
// Takes resolved writeback loads and the esi/edi string loads, holds the
// registers with synchronous reset and serves the two full-width address
// reads used for base and index of a scaled-index address.

`timescale 1ns/10ps

`include "gpr_config.svh"

module gpr_array
    import gpr_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  wb_load_t  load,
    input  str_upd_t  str,
    input  reg_idx_t  sib_base_idx,
    input  reg_idx_t  sib_index_idx,
    output word_t     sib_base_value,
    output word_t     sib_index_value,
    output gpr_bank_t regs
);

    localparam reg_idx_t ESI_IDX = 3'd6;
    localparam reg_idx_t EDI_IDX = 3'd7;

    gpr_bank_t              regs_q;
    gpr_bank_t              reg_d;
    logic [`GPR_COUNT-1:0]  reg_we;

    // ------------------------------------------------------------------------
    // per-register load enables and data
    // ------------------------------------------------------------------------

    always_comb begin
        for (int i = 0; i < `GPR_COUNT; i++) begin
            reg_we[i] = load.en && (load.idx == i);
            reg_d[i]  = load.data;
        end
        // string loads win over a writeback to the same register
        if (str.esi_en) begin
            reg_we[ESI_IDX] = 1'b1;
            reg_d[ESI_IDX]  = str.esi_data;
        end
        if (str.edi_en) begin
            reg_we[EDI_IDX] = 1'b1;
            reg_d[EDI_IDX]  = str.edi_data;
        end
    end

    // ------------------------------------------------------------------------
    // registers
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `GPR_COUNT; i++) begin
                regs_q[i] <= `GPR_RESET_VALUE;
            end
        end else begin
            for (int i = 0; i < `GPR_COUNT; i++) begin
                if (reg_we[i]) begin
                    regs_q[i] <= reg_d[i];
                end
            end
        end
    end

    // address reads ignore the operand size
    assign sib_base_value  = regs_q[sib_base_idx];
    assign sib_index_value = regs_q[sib_index_idx];
    assign regs            = regs_q;

endmodule

/* gpr_file.sv */
// Top level of the general register file.
// Two size-aware operand reads, two full-width address reads, one sized
// writeback and the esi/edi string loads. Reads are combinational and
// writes land on the rising clock edge.

`timescale 1ns/10ps

module gpr_file
    import gpr_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    // operand reads share one size
    input  opsize_t   read_size,
    input  reg_idx_t  op_1_idx,
    input  reg_idx_t  op_2_idx,
    output word_t     op_1_value,
    output word_t     op_2_value,

    // scaled-index address reads
    input  reg_idx_t  sib_base_idx,
    input  reg_idx_t  sib_index_idx,
    output word_t     sib_base_value,
    output word_t     sib_index_value,

    input  wb_req_t   wb,
    input  str_upd_t  str,
    output gpr_bank_t regs
);

    wb_load_t load;

    // ------------------------------------------------------------------------
    // write path
    // ------------------------------------------------------------------------

    gpr_write_merge wb_merge (
        .regs (regs),
        .wb   (wb),
        .load (load)
    );

    gpr_array array (
        .clk             (clk),
        .rst_n           (rst_n),
        .load            (load),
        .str             (str),
        .sib_base_idx    (sib_base_idx),
        .sib_index_idx   (sib_index_idx),
        .sib_base_value  (sib_base_value),
        .sib_index_value (sib_index_value),
        .regs            (regs)
    );

    // ------------------------------------------------------------------------
    // operand reads
    // ------------------------------------------------------------------------

    gpr_read_port op1_port (
        .regs  (regs),
        .idx   (op_1_idx),
        .size  (read_size),
        .value (op_1_value)
    );

    gpr_read_port op2_port (
        .regs  (regs),
        .idx   (op_2_idx),
        .size  (read_size),
        .value (op_2_value)
    );

endmodule

/* gpr_file_asserts.sv */
// Bound checker for the general register file.
// Keeps a shadow copy of the registers from the writeback, string-load
// and reset rules and checks the bank and every read port against it.
// Failures raise $error and are counted in fail_count.

`timescale 1ns/10ps

`include "gpr_config.svh"

module gpr_file_asserts
    import gpr_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input opsize_t   read_size,
    input reg_idx_t  op_1_idx,
    input reg_idx_t  op_2_idx,
    input word_t     op_1_value,
    input word_t     op_2_value,
    input reg_idx_t  sib_base_idx,
    input reg_idx_t  sib_index_idx,
    input word_t     sib_base_value,
    input word_t     sib_index_value,
    input wb_req_t   wb,
    input str_upd_t  str,
    input gpr_bank_t regs
);

    int        fail_count = 0;
    gpr_bank_t shadow;
    word_t     exp_op_1;
    word_t     exp_op_2;
    word_t     exp_base;
    word_t     exp_index;

    // operand view of the shadow bank, names 4-7 at byte size are ah..bh
    function automatic word_t operand_view(gpr_bank_t bank, reg_idx_t idx, opsize_t size);
        word_t result;
        result = '0;
        case (size)
            `GPR_SIZE_32: result = bank[idx];
            `GPR_SIZE_16: result = {16'h0000, bank[idx][15:0]};
            `GPR_SIZE_8: begin
                if (idx < 3'd4) begin
                    result = {24'h00_0000, bank[idx][7:0]};
                end else begin
                    result = {24'h00_0000, bank[idx - 3'd4][15:8]};
                end
            end
            default: result = '0;
        endcase
        return result;
    endfunction

    // ------------------------------------------------------------------------
    // shadow register model
    // ------------------------------------------------------------------------

    always @(posedge clk) begin : shadow_update
        gpr_bank_t nxt;
        nxt = shadow;
        if (!rst_n) begin
            for (int i = 0; i < `GPR_COUNT; i++) begin
                nxt[i] = `GPR_RESET_VALUE;
            end
        end else begin
            if (wb.en) begin
                case (wb.size)
                    `GPR_SIZE_32: nxt[wb.idx] = wb.data;
                    `GPR_SIZE_16: nxt[wb.idx][15:0] = wb.data[15:0];
                    `GPR_SIZE_8: begin
                        if (wb.idx < 3'd4) begin
                            nxt[wb.idx][7:0] = wb.data[7:0];
                        end else begin
                            nxt[wb.idx - 3'd4][15:8] = wb.data[7:0];
                        end
                    end
                    default: ;
                endcase
            end
            // direct loads land last so they win over the writeback
            if (str.esi_en) nxt[6] = str.esi_data;
            if (str.edi_en) nxt[7] = str.edi_data;
        end
        shadow <= nxt;
    end

    assign exp_op_1  = operand_view(shadow, op_1_idx, read_size);
    assign exp_op_2  = operand_view(shadow, op_2_idx, read_size);
    assign exp_base  = shadow[sib_base_idx];
    assign exp_index = shadow[sib_index_idx];

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------

    a_bank: assert property (@(posedge clk) disable iff (!rst_n) regs == shadow)
        else begin
            fail_count = fail_count + 1;
            $error("ERR bank: expected %h actual %h", $sampled(shadow), $sampled(regs));
        end

    a_op_1: assert property (@(posedge clk) disable iff (!rst_n) op_1_value == exp_op_1)
        else begin
            fail_count = fail_count + 1;
            $error("ERR op_1: expected %h actual %h", $sampled(exp_op_1), $sampled(op_1_value));
        end

    a_op_2: assert property (@(posedge clk) disable iff (!rst_n) op_2_value == exp_op_2)
        else begin
            fail_count = fail_count + 1;
            $error("ERR op_2: expected %h actual %h", $sampled(exp_op_2), $sampled(op_2_value));
        end

    a_base: assert property (@(posedge clk) disable iff (!rst_n) sib_base_value == exp_base)
        else begin
            fail_count = fail_count + 1;
            $error("ERR sib_base: expected %h actual %h",
                   $sampled(exp_base), $sampled(sib_base_value));
        end

    a_index: assert property (@(posedge clk) disable iff (!rst_n) sib_index_value == exp_index)
        else begin
            fail_count = fail_count + 1;
            $error("ERR sib_index: expected %h actual %h",
                   $sampled(exp_index), $sampled(sib_index_value));
        end

endmodule

/* tb_gpr_file.sv */
// Testbench for the general register file.
// Drives directed and random writebacks, string loads and reads into the
// DUT; the bound checker compares every port against its shadow model.
// Run through run_sim.sh, which compiles from sources.f.

`timescale 1ns/10ps

`include "gpr_config.svh"

module tb_gpr_file
    import gpr_pkg::*;
();

    // three times the directed and random cycles plus some slack
    localparam int RANDOM_CYCLES   = 400;
    localparam int DIRECTED_CYCLES = 200;
    localparam int MAX_CYCLES      = 3 * (RANDOM_CYCLES + DIRECTED_CYCLES) + 200;

    logic        clk;
    logic        rst_n;
    opsize_t     read_size;
    reg_idx_t    op_1_idx;
    reg_idx_t    op_2_idx;
    word_t       op_1_value;
    word_t       op_2_value;
    reg_idx_t    sib_base_idx;
    reg_idx_t    sib_index_idx;
    word_t       sib_base_value;
    word_t       sib_index_value;
    wb_req_t     wb;
    str_upd_t    str;
    gpr_bank_t   regs;
    logic [31:0] rand_state;
    int          cycle_count;
    string       test_name;

    gpr_file dut0 (
        .clk             (clk),
        .rst_n           (rst_n),
        .read_size       (read_size),
        .op_1_idx        (op_1_idx),
        .op_2_idx        (op_2_idx),
        .op_1_value      (op_1_value),
        .op_2_value      (op_2_value),
        .sib_base_idx    (sib_base_idx),
        .sib_index_idx   (sib_index_idx),
        .sib_base_value  (sib_base_value),
        .sib_index_value (sib_index_value),
        .wb              (wb),
        .str             (str),
        .regs            (regs)
    );

    bind gpr_file gpr_file_asserts chk0 (
        .clk             (clk),
        .rst_n           (rst_n),
        .read_size       (read_size),
        .op_1_idx        (op_1_idx),
        .op_2_idx        (op_2_idx),
        .op_1_value      (op_1_value),
        .op_2_value      (op_2_value),
        .sib_base_idx    (sib_base_idx),
        .sib_index_idx   (sib_index_idx),
        .sib_base_value  (sib_base_value),
        .sib_index_value (sib_index_value),
        .wb              (wb),
        .str             (str),
        .regs            (regs)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // LCG step
    function logic [31:0] random_word();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    // inputs change 1 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic set_wb(input logic en, input reg_idx_t idx, input opsize_t size,
                          input word_t data);
        wb.en   = en;
        wb.idx  = idx;
        wb.size = size;
        wb.data = data;
    endtask

    task automatic write_reg(input reg_idx_t idx, input opsize_t size, input word_t data);
        set_wb(1'b1, idx, size, data);
        step();
        wb.en = 1'b0;
    endtask

    // address ports take the operand indices crossed over
    task automatic point_reads(input opsize_t size, input reg_idx_t a, input reg_idx_t b);
        read_size     = size;
        op_1_idx      = a;
        op_2_idx      = b;
        sib_base_idx  = b;
        sib_index_idx = a;
    endtask

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------

    initial begin
        logic [31:0] r;
        int          fails;
        rand_state = 32'hc342_3a24;
        rst_n      = 1'b0;
        wb         = '0;
        str        = '0;
        test_name  = "reset";
        point_reads(`GPR_SIZE_32, 3'd0, 3'd0);
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // every port reads zero for every index and size
        for (int s = 0; s < 4; s++) begin
            for (int i = 0; i < 8; i++) begin
                point_reads(opsize_t'(s), reg_idx_t'(i), reg_idx_t'(7 - i));
                step();
            end
        end

        // both operand ports read the register written a cycle earlier
        test_name = "write32";
        for (int i = 0; i < 8; i++) begin
            point_reads(`GPR_SIZE_32, reg_idx_t'(i - 1), reg_idx_t'(i - 1));
            write_reg(reg_idx_t'(i), `GPR_SIZE_32, 32'h1122_3344 ^ (32'h0101_0101 * (i + 1)));
        end
        point_reads(`GPR_SIZE_32, 3'd7, 3'd7);
        step();

        test_name = "partial_write";
        for (int i = 0; i < 8; i++) begin
            point_reads(`GPR_SIZE_32, reg_idx_t'(i), reg_idx_t'(i % 4));
            write_reg(reg_idx_t'(i), `GPR_SIZE_16, 32'hffff_a500 + i);
        end
        for (int i = 0; i < 8; i++) begin
            point_reads(`GPR_SIZE_32, reg_idx_t'(i), reg_idx_t'(i % 4));
            write_reg(reg_idx_t'(i), `GPR_SIZE_8, 32'hffff_ff30 + i);
        end
        set_wb(1'b0, 3'd2, `GPR_SIZE_32, 32'hbad0_bad0);
        step();
        write_reg(3'd1, 2'd3, 32'hffff_ffff);
        step();

        test_name = "sized_reads";
        for (int s = 0; s < 4; s++) begin
            for (int i = 0; i < 8; i++) begin
                point_reads(opsize_t'(s), reg_idx_t'(i), reg_idx_t'((i + 3) % 8));
                step();
            end
        end

        test_name = "string_loads";
        point_reads(`GPR_SIZE_32, 3'd6, 3'd7);
        str = '{esi_en: 1'b1, esi_data: 32'h5151_0001, edi_en: 1'b0, edi_data: 32'h0};
        step();
        str = '{esi_en: 1'b0, esi_data: 32'h0, edi_en: 1'b1, edi_data: 32'hd1d1_0002};
        step();
        str = '{esi_en: 1'b1, esi_data: 32'h5151_0003, edi_en: 1'b1, edi_data: 32'hd1d1_0004};
        step();
        // direct load against a writeback to the same register
        str = '{esi_en: 1'b1, esi_data: 32'h5151_0005, edi_en: 1'b0, edi_data: 32'h0};
        write_reg(3'd6, `GPR_SIZE_32, 32'hbbbb_0006);
        str = '{esi_en: 1'b0, esi_data: 32'h0, edi_en: 1'b1, edi_data: 32'hd1d1_0007};
        write_reg(3'd7, `GPR_SIZE_16, 32'hbbbb_0008);
        // writeback to eax still lands beside both loads
        str = '{esi_en: 1'b1, esi_data: 32'h5151_0009, edi_en: 1'b1, edi_data: 32'hd1d1_000a};
        point_reads(`GPR_SIZE_32, 3'd0, 3'd6);
        write_reg(3'd0, `GPR_SIZE_32, 32'hcafe_000b);
        str = '0;
        step();
        // reset beats every load in flight
        rst_n = 1'b0;
        str   = '{esi_en: 1'b1, esi_data: 32'h5151_000c, edi_en: 1'b1, edi_data: 32'hd1d1_000d};
        write_reg(3'd3, `GPR_SIZE_32, 32'hcafe_000e);
        str   = '0;
        rst_n = 1'b1;
        step();

        // the low bits of an LCG repeat quickly so the fields use bits 8 and up
        test_name = "random";
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            r = random_word();
            set_wb(r[31], r[30:28], r[27:26], random_word());
            str.esi_en   = r[25] & r[24];
            str.esi_data = random_word();
            str.edi_en   = r[23] & r[22];
            str.edi_data = random_word();
            point_reads(r[21:20], r[19:17], r[16:14]);
            sib_base_idx  = r[13:11];
            sib_index_idx = r[10:8];
            step();
        end

        wb  = '0;
        str = '0;
        repeat (2) step();

        fails = dut0.chk0.fail_count;
        $display("error count: assertion failures %0d, timeouts 0", fails);
        if (fails == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // ------------------------------------------------------------------------
    // watchdog
    // ------------------------------------------------------------------------

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles, stuck in %s",
                 cycle_count, test_name);
        $display("error count: assertion failures %0d, timeouts 1", dut0.chk0.fail_count);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* sources.f */
+incdir+.
gpr_pkg.sv
gpr_read_port.sv
gpr_write_merge.sv
gpr_array.sv
gpr_file.sv
gpr_file_asserts.sv
tb_gpr_file.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the register file testbench with Verilator, runs it and checks the log.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_gpr_file \
    -f sources.f \
    -o sim_gpr_file

./obj_dir/sim_gpr_file +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
    echo "run_sim: failure reported, see sim.log"
    exit 1
fi

echo "run_sim: no failure reported"
exit 0
